/* rtl/raster_pkg.sv */
/*
  Shared types for the line and triangle outline rasterizer.
  Coordinates are unsigned, 10 bits each, with no range or clip checks.
  A command draws v0-v1 for a line, v0-v1-v2-v0 for a triangle.
  Pixel order follows integer Bresenham, ties step the minor axis.
*/
package raster_pkg;

	localparam int COORD_W = 10;
	localparam int ERR_W   = COORD_W + 2;   // Signed error term and deltas

	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} point_t;

	// Shape request, v2 unused for lines
	typedef struct packed {
		logic   triangle;
		point_t v0;
		point_t v1;
		point_t v2;
	} draw_cmd_t;

	// One edge handed to the line engine
	typedef struct packed {
		point_t start_pt;
		point_t end_pt;
		logic   last_seg;   // Final edge of the shape
	} segment_t;

	typedef struct packed {
		point_t pos;
		logic   last;       // Final pixel of the shape
	} pixel_t;

endpackage

/* rtl/stream_reg.sv */
/*
  Valid/ready register slice with a spare (skid) entry.
  Full throughput, in_ready comes straight from a flop.
  Input accepted on one edge is valid at the output after that edge.
  Payload registers are not reset.
*/
`timescale 1ns/1ps

module stream_reg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic n_rst,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);

	T     skid_data;
	logic skid_valid;
	logic skid_valid_nxt;
	logic out_valid_nxt;
	logic in_fire;
	logic load_main;

	assign in_fire   = in_valid && in_ready;
	assign load_main = !out_valid || out_ready;   // Main entry empty or draining
	assign in_ready  = !skid_valid;

	always_comb begin
		if (load_main) begin
			skid_valid_nxt = 1'b0;                  // Spare always empties into main
			out_valid_nxt  = skid_valid || in_fire;
		end else begin
			skid_valid_nxt = skid_valid || in_fire;
			out_valid_nxt  = 1'b1;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else begin
			out_valid  <= out_valid_nxt;
			skid_valid <= skid_valid_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (load_main && skid_valid)
			out_data <= skid_data;   // Older word goes first
		else if (load_main && in_fire)
			out_data <= in_data;
		if (!load_main && in_fire)
			skid_data <= in_data;
	end

endmodule

/* rtl/edge_sequencer.sv */
/*
  Breaks a draw command into edges for the line engine.
  Line gives one edge v0-v1; triangle gives v0-v1, v1-v2, v2-v0.
  One edge is in flight at a time, finished by seg_done.
  One idle cycle separates consecutive edges of a triangle.
  A new command is taken only in IDLE.
*/
`timescale 1ns/1ps

module edge_sequencer (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	input  raster_pkg::draw_cmd_t cmd,
	output logic                  seg_valid,
	input  logic                  seg_ready,
	output raster_pkg::segment_t  seg,
	input  logic                  seg_done
);

	typedef enum logic [2:0] {
		IDLE,
		EDGE_A,
		GAP_A,
		EDGE_B,
		GAP_B,
		EDGE_C
	} state_t;

	state_t state;
	state_t next_state;

	raster_pkg::draw_cmd_t cur_cmd;
	logic                  issued;   // Current edge already taken by the engine
	logic                  in_edge;

	assign cmd_ready = (state == IDLE);
	assign in_edge   = (state == EDGE_A) || (state == EDGE_B) || (state == EDGE_C);
	assign seg_valid = in_edge && !issued;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cmd_valid)
					next_state = EDGE_A;
			end
			EDGE_A: begin
				if (seg_done)
					next_state = cur_cmd.triangle ? GAP_A : IDLE;
			end
			GAP_A: next_state = EDGE_B;
			EDGE_B: begin
				if (seg_done)
					next_state = GAP_B;
			end
			GAP_B: next_state = EDGE_C;
			EDGE_C: begin
				if (seg_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	// Edge endpoints picked from the latched vertices
	always_comb begin
		seg.start_pt = cur_cmd.v0;
		seg.end_pt   = cur_cmd.v1;
		seg.last_seg = !cur_cmd.triangle;   // Only edge of a line
		case (state)
			EDGE_B: begin
				seg.start_pt = cur_cmd.v1;
				seg.end_pt   = cur_cmd.v2;
				seg.last_seg = 1'b0;
			end
			EDGE_C: begin
				seg.start_pt = cur_cmd.v2;
				seg.end_pt   = cur_cmd.v0;
				seg.last_seg = 1'b1;             // Closing edge
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state  <= IDLE;
			issued <= 1'b0;
		end else begin
			state <= next_state;
			if (seg_done)
				issued <= 1'b0;
			else if (seg_valid && seg_ready)
				issued <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready)
			cur_cmd <= cmd;
	end

endmodule

/* rtl/line_engine.sv */
/*
  Bresenham line stepper, one pixel per accepted output transfer.
  Both endpoints are emitted, N = max(|dx|, |dy|) + 1 pixels per edge.
  Error rule: e2 = 2*err, e2 >= dy steps x, e2 <= dx steps y.
  Takes a new edge only when idle; seg_done pulses as the end pixel
  is accepted downstream.
*/
`timescale 1ns/1ps

module line_engine (
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 seg_valid,
	output logic                 seg_ready,
	input  raster_pkg::segment_t seg,
	output logic                 pix_valid,
	input  logic                 pix_ready,
	output raster_pkg::pixel_t   pix,
	output logic                 seg_done
);

	logic busy;

	raster_pkg::point_t cur_pos;
	raster_pkg::point_t end_pos;
	logic               last_seg;
	logic               x_inc;      // Step direction of the current edge
	logic               y_inc;

	logic signed [raster_pkg::ERR_W-1:0] dx;    // |dx|
	logic signed [raster_pkg::ERR_W-1:0] dy;    // -|dy|
	logic signed [raster_pkg::ERR_W-1:0] err;
	logic signed [raster_pkg::ERR_W-1:0] err_nxt;
	logic signed [raster_pkg::ERR_W:0]   e2;

	// Incoming edge set-up
	logic [raster_pkg::COORD_W-1:0]      dx_abs;
	logic [raster_pkg::COORD_W-1:0]      dy_abs;
	logic                                new_x_inc;
	logic                                new_y_inc;
	logic signed [raster_pkg::ERR_W-1:0] dx_ext;
	logic signed [raster_pkg::ERR_W-1:0] dy_ext;

	logic seg_fire;
	logic pix_fire;
	logic at_end;
	logic step_x;
	logic step_y;

	assign seg_ready = !busy;
	assign pix_valid = busy;
	assign seg_fire  = seg_valid && seg_ready;
	assign pix_fire  = pix_valid && pix_ready;
	assign at_end    = (cur_pos.x == end_pos.x) && (cur_pos.y == end_pos.y);
	assign seg_done  = pix_fire && at_end;

	always_comb begin
		pix.pos  = cur_pos;
		pix.last = at_end && last_seg;
	end

	always_comb begin
		if (seg.end_pt.x >= seg.start_pt.x) begin
			dx_abs    = seg.end_pt.x - seg.start_pt.x;
			new_x_inc = 1'b1;
		end else begin
			dx_abs    = seg.start_pt.x - seg.end_pt.x;
			new_x_inc = 1'b0;
		end
		if (seg.end_pt.y >= seg.start_pt.y) begin
			dy_abs    = seg.end_pt.y - seg.start_pt.y;
			new_y_inc = 1'b1;
		end else begin
			dy_abs    = seg.start_pt.y - seg.end_pt.y;
			new_y_inc = 1'b0;
		end
		dx_ext = {2'b00, dx_abs};
		dy_ext = {2'b00, dy_abs};
	end

	// Ties (e2 equal to a bound) take the minor axis step
	assign e2     = {err, 1'b0};
	assign step_x = (e2 >= dy);
	assign step_y = (e2 <= dx);

	always_comb begin
		err_nxt = err;
		if (step_x)
			err_nxt = err_nxt + dy;
		if (step_y)
			err_nxt = err_nxt + dx;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			busy <= 1'b0;
		else if (seg_fire)
			busy <= 1'b1;
		else if (seg_done)
			busy <= 1'b0;   // End pixel handed over
	end

	always_ff @(posedge clk) begin
		if (seg_fire) begin
			cur_pos  <= seg.start_pt;
			end_pos  <= seg.end_pt;
			last_seg <= seg.last_seg;
			x_inc    <= new_x_inc;
			y_inc    <= new_y_inc;
			dx       <= dx_ext;
			dy       <= -dy_ext;
			err      <= dx_ext - dy_ext;
		end else if (pix_fire && !at_end) begin
			if (step_x)
				cur_pos.x <= x_inc ? cur_pos.x + 1'b1 : cur_pos.x - 1'b1;
			if (step_y)
				cur_pos.y <= y_inc ? cur_pos.y + 1'b1 : cur_pos.y - 1'b1;
			err <= err_nxt;
		end
	end

endmodule

/* rtl/raster_top.sv */
/*
  Outline rasterizer top: input slice, edge sequencer, line engine,
  output slice. Latency varies with the shape and back-pressure.
  End of a shape is the pixel with last set.
*/
`timescale 1ns/1ps

module raster_top (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	input  raster_pkg::draw_cmd_t cmd,
	output logic                  pix_valid,
	input  logic                  pix_ready,
	output raster_pkg::pixel_t    pix
);

	// Registered command toward the sequencer
	logic                  cmd_q_valid;
	logic                  cmd_q_ready;
	raster_pkg::draw_cmd_t cmd_q;

	logic                 seg_valid;
	logic                 seg_ready;
	raster_pkg::segment_t seg;
	logic                 seg_done;

	// Engine output before the output slice
	logic               eng_pix_valid;
	logic               eng_pix_ready;
	raster_pkg::pixel_t eng_pix;

	stream_reg #(.T(raster_pkg::draw_cmd_t)) cmd_slice_i (
		.clk       (clk),
		.n_rst     (n_rst),
		.in_valid  (cmd_valid),
		.in_ready  (cmd_ready),
		.in_data   (cmd),
		.out_valid (cmd_q_valid),
		.out_ready (cmd_q_ready),
		.out_data  (cmd_q)
	);

	edge_sequencer seq_i (
		.clk       (clk),
		.n_rst     (n_rst),
		.cmd_valid (cmd_q_valid),
		.cmd_ready (cmd_q_ready),
		.cmd       (cmd_q),
		.seg_valid (seg_valid),
		.seg_ready (seg_ready),
		.seg       (seg),
		.seg_done  (seg_done)
	);

	line_engine engine_i (
		.clk       (clk),
		.n_rst     (n_rst),
		.seg_valid (seg_valid),
		.seg_ready (seg_ready),
		.seg       (seg),
		.pix_valid (eng_pix_valid),
		.pix_ready (eng_pix_ready),
		.pix       (eng_pix),
		.seg_done  (seg_done)
	);

	stream_reg #(.T(raster_pkg::pixel_t)) pix_slice_i (
		.clk       (clk),
		.n_rst     (n_rst),
		.in_valid  (eng_pix_valid),
		.in_ready  (eng_pix_ready),
		.in_data   (eng_pix),
		.out_valid (pix_valid),
		.out_ready (pix_ready),
		.out_data  (pix)
	);

endmodule

/* sim/tb_raster_top.sv */
/*
  Testbench for raster_top. Commands and expected pixels come from
  sim/raster_golden.txt, so the run must start in the project root.
  Commands are sent back to back. pix_ready is random, about 70 % high.
  Each accepted pixel must equal the next golden entry, in order.
  The run is bounded by 20 cycles per expected pixel plus 200.
*/
`timescale 1ns/1ps

module tb_raster_top;

	logic                  clk;
	logic                  n_rst;
	logic                  cmd_valid;
	logic                  cmd_ready;
	raster_pkg::draw_cmd_t cmd;
	logic                  pix_valid;
	logic                  pix_ready;
	raster_pkg::pixel_t    pix;

	raster_pkg::draw_cmd_t cmd_list[$];
	raster_pkg::pixel_t    exp_list[$];

	int got;          // Pixels accepted so far
	int cycles;       // Cycles since reset release
	int limit;
	int mismatches;
	int extras;
	int missing;
	int file_errs;

	raster_top dut_i (
		.clk       (clk),
		.n_rst     (n_rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix       (pix)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;   // 8 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// C lines become commands, P lines expected pixels, # lines are skipped
	task automatic load_golden();
		int fd;
		int code;
		int tri_flag;
		int x0, y0, x1, y1, x2, y2;
		int px, py, pl;
		logic [7:0] kind;
		logic [8*128-1:0] rest;
		logic done;
		raster_pkg::draw_cmd_t c;
		raster_pkg::pixel_t p;
		fd = $fopen("sim/raster_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/raster_golden.txt, no stimulus available");
			file_errs++;
			return;
		end
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				done = 1'b1;   // End of file
			end else if (kind == "#") begin
				code = $fgets(rest, fd);
			end else if (kind == "C") begin
				code = $fscanf(fd, "%d %d %d %d %d %d %d",
					tri_flag, x0, y0, x1, y1, x2, y2);
				if (code != 7) begin
					$display("Golden file has a command line with missing fields");
					file_errs++;
				end
				c.triangle = tri_flag[0];
				c.v0.x = x0[raster_pkg::COORD_W-1:0];
				c.v0.y = y0[raster_pkg::COORD_W-1:0];
				c.v1.x = x1[raster_pkg::COORD_W-1:0];
				c.v1.y = y1[raster_pkg::COORD_W-1:0];
				c.v2.x = x2[raster_pkg::COORD_W-1:0];
				c.v2.y = y2[raster_pkg::COORD_W-1:0];
				cmd_list.push_back(c);
			end else if (kind == "P") begin
				code = $fscanf(fd, "%d %d %d", px, py, pl);
				if (code != 3) begin
					$display("Golden file has a pixel line with missing fields");
					file_errs++;
				end
				p.pos.x = px[raster_pkg::COORD_W-1:0];
				p.pos.y = py[raster_pkg::COORD_W-1:0];
				p.last  = pl[0];
				exp_list.push_back(p);
			end else begin
				$display("Golden file has a line of unknown kind '%c'", kind);
				file_errs++;
				code = $fgets(rest, fd);
			end
		end
		$fclose(fd);
		if (exp_list.size() == 0) begin
			$display("Golden file holds no expected pixels");
			file_errs++;
		end
	endtask

	// Command driver, one command after another
	initial begin
		cmd_valid <= 1'b0;
		cmd       <= '0;
		wait (n_rst === 1'b1);
		@(posedge clk);
		foreach (cmd_list[i]) begin
			cmd_valid <= 1'b1;
			cmd       <= cmd_list[i];
			@(negedge clk);
			while (!cmd_ready)
				@(negedge clk);   // Ready seen mid-cycle, taken on next edge
			@(posedge clk);
		end
		cmd_valid <= 1'b0;
	end

	// Random back-pressure on the pixel output
	initial begin : ready_gen
		logic [31:0] rng;
		rng = 32'd44723;
		pix_ready <= 1'b0;
		forever begin
			@(posedge clk);
			rng = lcg_next(rng);
			pix_ready <= ((rng >> 16) % 32'd10) < 32'd7;
		end
	end

	always @(posedge clk) begin
		if (!n_rst) begin
			cycles <= 0;
			got    <= 0;
		end else begin
			cycles <= cycles + 1;
			if (pix_valid && pix_ready) begin
				assert (got < exp_list.size()) else begin
					extras++;
					$display("Pixel (%0d,%0d) arrived after all expected pixels",
						pix.pos.x, pix.pos.y);
				end
				if (got < exp_list.size()) begin
					assert (pix == exp_list[got]) else begin
						mismatches++;
						$display("[FAIL] %0t ns: pixel %0d is (%0d,%0d) last=%0b, %s",
							$time, got, pix.pos.x, pix.pos.y, pix.last,
							$sformatf("expected (%0d,%0d) last=%0b",
								exp_list[got].pos.x, exp_list[got].pos.y,
								exp_list[got].last));
					end
				end
				got <= got + 1;
			end
		end
	end

	initial begin
		n_rst <= 1'b0;
		load_golden();
		limit = 20 * exp_list.size() + 200;
		repeat (3) @(posedge clk);
		n_rst <= 1'b1;
		@(posedge clk);
		while (got < exp_list.size() && cycles < limit)
			@(posedge clk);
		if (got < exp_list.size()) begin
			missing = exp_list.size() - got;
			$display("Timeout after %0d cycles, %0d expected pixels were missing",
				cycles, missing);
		end
		repeat (20) @(posedge clk);   // Room for stray extra pixels
		$display("Errors: %0d mismatched, %0d missing, %0d extra, %0d golden file",
			mismatches, missing, extras, file_errs);
		if (mismatches + missing + extras + file_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* sim/raster_golden.txt */
# C triangle x0 y0 x1 y1 x2 y2 : command, triangle is 0 for a line (v2 then unused)
# P x y last : expected pixel in output order, last is 1 on the final pixel of a shape
C 0 2 3 6 3 0 0
P 2 3 0
P 3 3 0
P 4 3 0
P 5 3 0
P 6 3 1
C 0 5 8 5 5 0 0
P 5 8 0
P 5 7 0
P 5 6 0
P 5 5 1
C 0 10 10 7 13 0 0
P 10 10 0
P 9 11 0
P 8 12 0
P 7 13 1
C 0 20 20 19 16 0 0
P 20 20 0
P 20 19 0
P 19 18 0
P 19 17 0
P 19 16 1
C 0 0 0 2 1 0 0
P 0 0 0
P 1 1 0
P 2 1 1
C 0 7 7 7 7 3 9
P 7 7 1
C 0 0 0 2 1 1023 511
P 0 0 0
P 1 1 0
P 2 1 1
C 1 0 0 4 0 0 3
P 0 0 0
P 1 0 0
P 2 0 0
P 3 0 0
P 4 0 0
P 4 0 0
P 3 1 0
P 2 2 0
P 1 2 0
P 0 3 0
P 0 3 0
P 0 2 0
P 0 1 0
P 0 0 1

/* raster_top.f */
rtl/raster_pkg.sv
rtl/stream_reg.sv
rtl/edge_sequencer.sv
rtl/line_engine.sv
rtl/raster_top.sv
sim/tb_raster_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the raster_top testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_raster_top \
	-Mdir build \
	-f raster_top.f

./build/Vtb_raster_top | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
	echo "Result: passed"
	exit 0
else
	echo "Result: failed"
	exit 1
fi
